// File: logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Input queue entries and the upstream credits after reset
`define CORE_IN_DEPTH 4

// Retire records the core may send before a credit returns
`define CORE_OUT_CREDITS 4

// Architectural registers
`define CORE_NUM_REGS 8

`endif

// File: logic/corePkg.sv
`default_nettype none

package corePkg;

        typedef logic [15:0] word_t;
        typedef logic [15:0] instr_t;
        typedef logic [2:0]  regIdx_t;

        typedef enum logic [3:0] {
                opAdd,          // A + B
                opRsub,         // B - A
                opXor,
                opAndn,         // A & ~B
                opRol,
                opSll,
                opRor,
                opSrl,
                opSeq,
                opSlt,
                opSle,
                opSco,          // Carry of A + B
                opLbi,
                opSlbi
        } aluOp_t;

        typedef struct packed {
                logic    valid;
                aluOp_t  aluOp;
                regIdx_t rsIdx;
                regIdx_t rtIdx;
                logic    immSel;        // Second operand is imm, not Rt
                word_t   imm;           // Already extended
                logic    wrEn;
                regIdx_t wrIdx;
                logic    halt;
                logic    illegal;
        } decodeRec_t;

        typedef struct packed {
                logic    wrEn;
                regIdx_t wrIdx;
                word_t   result;
                logic    halt;
                logic    illegal;
        } retireRec_t;

endpackage

`default_nettype wire

// File: logic/instrQueue.sv
`default_nettype none
`include "core_config.svh"

module instrQueue (
        input  logic            clk,
        input  logic            arstN,
        input  logic            inValid,
        input  corePkg::instr_t inInstr,
        input  logic            pop,
        output logic            headValid,
        output corePkg::instr_t headInstr,
        output logic            inCredit
);

        localparam int Depth = `CORE_IN_DEPTH;
        localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
        localparam int CntW  = $clog2(Depth + 1);

        corePkg::instr_t mem [Depth];
        logic [PtrW-1:0] wrPtr, rdPtr;
        logic [CntW-1:0] count;
        logic            full, doPop;

        assign headValid = (count != '0);
        assign full      = (count == CntW'(Depth));
        assign doPop     = pop && headValid;
        assign headInstr = mem[rdPtr];

        always_ff @(posedge clk) begin
                if (inValid)
                        mem[wrPtr] <= inInstr;
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        wrPtr    <= '0;
                        rdPtr    <= '0;
                        count    <= '0;
                        inCredit <= 1'b0;
                end else begin
                        if (inValid)
                                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
                        if (doPop)
                                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
                        case ({inValid, doPop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                        inCredit <= doPop;      // One credit per released entry
                end
        end

        // Upstream must never run past its credits
        assert property (@(posedge clk) disable iff (!arstN) inValid |-> !full)
                else $error("instrQueue: write while full");

        assert property (@(posedge clk) disable iff (!arstN) pop |-> headValid)
                else $error("instrQueue: pop while empty");

endmodule

`default_nettype wire

// File: logic/controlDecode.sv
`default_nettype none

module controlDecode (
        input  logic                clk,
        input  logic                arstN,
        input  logic                advance,
        input  logic                headValid,
        input  corePkg::instr_t     headInstr,
        output logic                pop,
        output corePkg::decodeRec_t decRec
);

        logic [4:0]          opcode;
        logic [1:0]          funct;
        corePkg::word_t      imm5S, imm5Z, imm8S, imm8Z;
        corePkg::decodeRec_t rec;

        function automatic corePkg::aluOp_t arithOp(input logic [1:0] sel);
                case (sel)
                        2'd0:    return corePkg::opAdd;
                        2'd1:    return corePkg::opRsub;
                        2'd2:    return corePkg::opXor;
                        default: return corePkg::opAndn;
                endcase
        endfunction

        function automatic corePkg::aluOp_t shiftOp(input logic [1:0] sel);
                case (sel)
                        2'd0:    return corePkg::opRol;
                        2'd1:    return corePkg::opSll;
                        2'd2:    return corePkg::opRor;
                        default: return corePkg::opSrl;
                endcase
        endfunction

        function automatic corePkg::aluOp_t cmpOp(input logic [1:0] sel);
                case (sel)
                        2'd0:    return corePkg::opSeq;
                        2'd1:    return corePkg::opSlt;
                        2'd2:    return corePkg::opSle;
                        default: return corePkg::opSco;
                endcase
        endfunction

        assign opcode = headInstr[15:11];
        assign funct  = headInstr[1:0];
        assign imm5S  = {{11{headInstr[4]}}, headInstr[4:0]};
        assign imm5Z  = {11'b0, headInstr[4:0]};
        assign imm8S  = {{8{headInstr[7]}}, headInstr[7:0]};
        assign imm8Z  = {8'b0, headInstr[7:0]};
        assign pop    = advance && headValid;

        always_comb begin
                rec         = '0;
                rec.valid   = headValid;
                rec.aluOp   = corePkg::opAdd;
                rec.rsIdx   = headInstr[10:8];
                rec.rtIdx   = headInstr[7:5];
                case (opcode)
                        5'b00000: rec.halt = 1'b1;
                        5'b00001: ;                             // NOP
                        5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
                                rec.aluOp  = arithOp(opcode[1:0]);
                                rec.immSel = 1'b1;
                                rec.imm    = opcode[1] ? imm5Z : imm5S;  // ADDI, SUBI signed
                                rec.wrEn   = 1'b1;
                                rec.wrIdx  = headInstr[7:5];
                        end
                        5'b10100, 5'b10101, 5'b10110, 5'b10111: begin
                                rec.aluOp  = shiftOp(opcode[1:0]);
                                rec.immSel = 1'b1;
                                rec.imm    = imm5Z;
                                rec.wrEn   = 1'b1;
                                rec.wrIdx  = headInstr[7:5];
                        end
                        5'b11011: begin
                                rec.aluOp = arithOp(funct);
                                rec.wrEn  = 1'b1;
                                rec.wrIdx = headInstr[4:2];
                        end
                        5'b11010: begin
                                rec.aluOp = shiftOp(funct);
                                rec.wrEn  = 1'b1;
                                rec.wrIdx = headInstr[4:2];
                        end
                        5'b11100, 5'b11101, 5'b11110, 5'b11111: begin
                                rec.aluOp = cmpOp(opcode[1:0]);
                                rec.wrEn  = 1'b1;
                                rec.wrIdx = headInstr[4:2];
                        end
                        5'b11000: begin                         // LBI
                                rec.aluOp  = corePkg::opLbi;
                                rec.immSel = 1'b1;
                                rec.imm    = imm8S;
                                rec.wrEn   = 1'b1;
                                rec.wrIdx  = headInstr[10:8];
                        end
                        5'b10010: begin                         // SLBI
                                rec.aluOp  = corePkg::opSlbi;
                                rec.immSel = 1'b1;
                                rec.imm    = imm8Z;
                                rec.wrEn   = 1'b1;
                                rec.wrIdx  = headInstr[10:8];
                        end
                        default: rec.illegal = 1'b1;            // Memory, branch, jump, undefined
                endcase
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN)
                        decRec <= '0;
                else if (advance)
                        decRec <= headValid ? rec : '0;
        end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none
`include "core_config.svh"

module regFile (
        input  logic             clk,
        input  logic             arstN,
        input  corePkg::regIdx_t rdIdxA,
        input  corePkg::regIdx_t rdIdxB,
        output corePkg::word_t   rdDataA,
        output corePkg::word_t   rdDataB,
        input  logic             wrEn,
        input  corePkg::regIdx_t wrIdx,
        input  corePkg::word_t   wrData
);

        corePkg::word_t regs [`CORE_NUM_REGS];

        assign rdDataA = regs[rdIdxA];
        assign rdDataB = regs[rdIdxB];

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < `CORE_NUM_REGS; i++)
                                regs[i] <= '0;
                end else if (wrEn) begin
                        regs[wrIdx] <= wrData;
                end
        end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`default_nettype none

module executeStage (
        input  logic                clk,
        input  logic                arstN,
        input  logic                advance,
        input  corePkg::decodeRec_t decRec,
        output corePkg::regIdx_t    rdIdxA,
        output corePkg::regIdx_t    rdIdxB,
        input  corePkg::word_t      rdDataA,
        input  corePkg::word_t      rdDataB,
        input  corePkg::retireRec_t fwdRec,
        input  logic                fwdValid,
        output corePkg::retireRec_t exRec,
        output logic                exValid
);

        corePkg::word_t      opA, opRt, opB, result;
        logic [3:0]          shAmt;
        logic [16:0]         sum;
        logic [31:0]         rolWide, rorWide;
        corePkg::retireRec_t nxtRec;

        assign rdIdxA = decRec.rsIdx;
        assign rdIdxB = decRec.rtIdx;

        // Own output register is newest, then the retire register, then the file
        assign opA = (exValid && exRec.wrEn && exRec.wrIdx == decRec.rsIdx) ? exRec.result :
                     (fwdValid && fwdRec.wrEn && fwdRec.wrIdx == decRec.rsIdx) ? fwdRec.result :
                     rdDataA;
        assign opRt = (exValid && exRec.wrEn && exRec.wrIdx == decRec.rtIdx) ? exRec.result :
                      (fwdValid && fwdRec.wrEn && fwdRec.wrIdx == decRec.rtIdx) ? fwdRec.result :
                      rdDataB;

        assign opB     = decRec.immSel ? decRec.imm : opRt;
        assign shAmt   = opB[3:0];
        assign sum     = {1'b0, opA} + {1'b0, opB};
        assign rolWide = {opA, opA} << shAmt;
        assign rorWide = {opA, opA} >> shAmt;

        always_comb begin
                result = '0;
                case (decRec.aluOp)
                        corePkg::opAdd:  result = sum[15:0];
                        corePkg::opRsub: result = opB - opA;
                        corePkg::opXor:  result = opA ^ opB;
                        corePkg::opAndn: result = opA & ~opB;
                        corePkg::opRol:  result = rolWide[31:16];
                        corePkg::opSll:  result = opA << shAmt;
                        corePkg::opRor:  result = rorWide[15:0];
                        corePkg::opSrl:  result = opA >> shAmt;
                        corePkg::opSeq:  result = {15'b0, opA == opB};
                        corePkg::opSlt:  result = {15'b0, $signed(opA) < $signed(opB)};
                        corePkg::opSle:  result = {15'b0, $signed(opA) <= $signed(opB)};
                        corePkg::opSco:  result = {15'b0, sum[16]};
                        corePkg::opLbi:  result = decRec.imm;
                        corePkg::opSlbi: result = (opA << 8) | decRec.imm;
                        default:         result = '0;
                endcase
        end

        always_comb begin
                nxtRec         = '0;
                nxtRec.wrEn    = decRec.wrEn;
                nxtRec.wrIdx   = decRec.wrIdx;
                nxtRec.result  = result;
                nxtRec.halt    = decRec.halt;
                nxtRec.illegal = decRec.illegal;
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        exValid <= 1'b0;
                        exRec   <= '0;
                end else if (advance) begin
                        exValid <= decRec.valid;
                        exRec   <= decRec.valid ? nxtRec : '0;
                end
        end

endmodule

`default_nettype wire

// File: logic/retireStage.sv
`default_nettype none
`include "core_config.svh"

module retireStage (
        input  logic                clk,
        input  logic                arstN,
        input  corePkg::retireRec_t exRec,
        input  logic                exValid,
        input  logic                outCredit,
        output logic                advance,
        output logic                retValid,
        output corePkg::retireRec_t retRec,
        output logic                wrEn,
        output corePkg::regIdx_t    wrIdx,
        output corePkg::word_t      wrData,
        output logic                fwdValid
);

        localparam int CntW = $clog2(`CORE_OUT_CREDITS + 1);

        logic            held;          // Retire register occupied
        logic [CntW-1:0] credCnt;

        assign retValid = held && (credCnt != '0);
        assign advance  = !held || (credCnt != '0);
        assign fwdValid = held;
        assign wrEn     = retValid && retRec.wrEn;   // Write as the record leaves
        assign wrIdx    = retRec.wrIdx;
        assign wrData   = retRec.result;

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        held    <= 1'b0;
                        retRec  <= '0;
                        credCnt <= CntW'(`CORE_OUT_CREDITS);
                end else begin
                        if (advance) begin
                                held   <= exValid;
                                retRec <= exRec;
                        end
                        credCnt <= credCnt - CntW'(retValid) + CntW'(outCredit);
                end
        end

        // Downstream returns no more than it was given
        assert property (@(posedge clk) disable iff (!arstN)
                credCnt <= CntW'(`CORE_OUT_CREDITS))
                else $error("retireStage: credit count overflow");

endmodule

`default_nettype wire

// File: logic/coreTop.sv
`default_nettype none

module coreTop (
        input  logic                clk,
        input  logic                arstN,
        input  logic                inValid,
        input  corePkg::instr_t     inInstr,
        output logic                inCredit,
        output logic                retValid,
        output corePkg::retireRec_t retRec,
        input  logic                outCredit
);

        logic                advance, pop, headValid, exValid, fwdValid, wrEn;
        corePkg::instr_t     headInstr;
        corePkg::decodeRec_t decRec;
        corePkg::retireRec_t exRec;
        corePkg::regIdx_t    rdIdxA, rdIdxB, wrIdx;
        corePkg::word_t      rdDataA, rdDataB, wrData;

        instrQueue uQueue (
                .clk       (clk),
                .arstN     (arstN),
                .inValid   (inValid),
                .inInstr   (inInstr),
                .pop       (pop),
                .headValid (headValid),
                .headInstr (headInstr),
                .inCredit  (inCredit)
        );

        controlDecode uDecode (
                .clk       (clk),
                .arstN     (arstN),
                .advance   (advance),
                .headValid (headValid),
                .headInstr (headInstr),
                .pop       (pop),
                .decRec    (decRec)
        );

        regFile uRegs (
                .clk     (clk),
                .arstN   (arstN),
                .rdIdxA  (rdIdxA),
                .rdIdxB  (rdIdxB),
                .rdDataA (rdDataA),
                .rdDataB (rdDataB),
                .wrEn    (wrEn),
                .wrIdx   (wrIdx),
                .wrData  (wrData)
        );

        executeStage uExecute (
                .clk      (clk),
                .arstN    (arstN),
                .advance  (advance),
                .decRec   (decRec),
                .rdIdxA   (rdIdxA),
                .rdIdxB   (rdIdxB),
                .rdDataA  (rdDataA),
                .rdDataB  (rdDataB),
                .fwdRec   (retRec),
                .fwdValid (fwdValid),
                .exRec    (exRec),
                .exValid  (exValid)
        );

        retireStage uRetire (
                .clk       (clk),
                .arstN     (arstN),
                .exRec     (exRec),
                .exValid   (exValid),
                .outCredit (outCredit),
                .advance   (advance),
                .retValid  (retValid),
                .retRec    (retRec),
                .wrEn      (wrEn),
                .wrIdx     (wrIdx),
                .wrData    (wrData),
                .fwdValid  (fwdValid)
        );

endmodule

`default_nettype wire

// File: bench/tbCore.sv
`default_nettype none
`include "core_config.svh"

module tbCore;

        localparam int DirLen     = 9;
        localparam int FastLen    = 200;
        localparam int SlowLen    = 200;
        localparam int CycleLimit = 20 * (DirLen + FastLen + SlowLen) + 100;

        logic                clk;
        logic                arstN;
        logic                inValid;
        corePkg::instr_t     inInstr;
        logic                inCredit;
        logic                retValid;
        corePkg::retireRec_t retRec;
        logic                outCredit;

        corePkg::word_t      modelRegs [`CORE_NUM_REGS];
        corePkg::retireRec_t expQ [$];
        corePkg::instr_t     dirSeq [DirLen];
        int                  inCred, coreCred, owed, credPct;
        int                  sent, received, creditsBack, errors, cycles, tests;

        coreTop UUT (
                .clk       (clk),
                .arstN     (arstN),
                .inValid   (inValid),
                .inInstr   (inInstr),
                .inCredit  (inCredit),
                .retValid  (retValid),
                .retRec    (retRec),
                .outCredit (outCredit)
        );

        always #10 clk = ~clk;

        task automatic compareVal(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
                if (got !== exp) begin
                        $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
                        errors++;
                end
        endtask

        // Select codes 0..3 arith, 4..7 shift and rotate, 8..11 compare
        function automatic corePkg::word_t aluModel(input logic [3:0] sel,
                                                    input corePkg::word_t a,
                                                    input corePkg::word_t b);
                logic [3:0] n;
                n = b[3:0];
                case (sel)
                        4'h0:    return a + b;
                        4'h1:    return b - a;
                        4'h2:    return a ^ b;
                        4'h3:    return a & ~b;
                        4'h4:    return (a << n) | (a >> (16 - n));
                        4'h5:    return a << n;
                        4'h6:    return (a >> n) | (a << (16 - n));
                        4'h7:    return a >> n;
                        4'h8:    return {15'b0, a == b};
                        4'h9:    return {15'b0, $signed(a) < $signed(b)};
                        4'hA:    return {15'b0, $signed(a) <= $signed(b)};
                        default: return {15'b0, corePkg::word_t'(a + b) < a};  // Wrapped sum
                endcase
        endfunction

        task automatic modelInstr(input corePkg::instr_t w);
                corePkg::retireRec_t e;
                corePkg::word_t      a, b, imm5;
                logic [4:0]          op;
                op   = w[15:11];
                a    = modelRegs[w[10:8]];
                b    = modelRegs[w[7:5]];
                imm5 = {11'b0, w[4:0]};
                e    = '0;
                casez (op)
                        5'b00000: e.halt = 1'b1;
                        5'b00001: ;
                        5'b010??: begin
                                if (!op[1])
                                        imm5 = {{11{w[4]}}, w[4:0]};    // ADDI, SUBI signed
                                e.result = aluModel({2'b00, op[1:0]}, a, imm5);
                                e.wrIdx  = w[7:5];
                        end
                        5'b101??: begin
                                e.result = aluModel({2'b01, op[1:0]}, a, imm5);
                                e.wrIdx  = w[7:5];
                        end
                        5'b11011: begin
                                e.result = aluModel({2'b00, w[1:0]}, a, b);
                                e.wrIdx  = w[4:2];
                        end
                        5'b11010: begin
                                e.result = aluModel({2'b01, w[1:0]}, a, b);
                                e.wrIdx  = w[4:2];
                        end
                        5'b111??: begin
                                e.result = aluModel({2'b10, op[1:0]}, a, b);
                                e.wrIdx  = w[4:2];
                        end
                        5'b11000: begin
                                e.result = {{8{w[7]}}, w[7:0]};
                                e.wrIdx  = w[10:8];
                        end
                        5'b10010: begin
                                e.result = (a << 8) | {8'b0, w[7:0]};
                                e.wrIdx  = w[10:8];
                        end
                        default: e.illegal = 1'b1;
                endcase
                e.wrEn = !(e.halt || e.illegal || op == 5'b00001);
                if (e.wrEn)
                        modelRegs[e.wrIdx] = e.result;
                expQ.push_back(e);
        endtask

        function automatic corePkg::instr_t randInstr();
                logic [31:0] r;
                r = $urandom;
                case ($urandom_range(0, 10))
                        0:       return r[15:0];
                        1:       return {3'b010, r[12:0]};
                        2:       return {3'b101, r[12:0]};
                        3, 4:    return {5'b11011, r[10:0]};
                        5:       return {5'b11010, r[10:0]};
                        6:       return {3'b111, r[12:0]};
                        7:       return {5'b11000, r[10:0]};
                        8:       return {5'b10010, r[10:0]};
                        9:       return {4'b0000, r[11:0]};     // HALT or NOP
                        default: return {2'b00, 3'($urandom_range(2, 7)), r[10:0]};
                endcase
        endfunction

        task automatic sendInstr(input corePkg::instr_t w);
                while (inCred == 0)
                        @(negedge clk);
                inValid = 1'b1;
                inInstr = w;
                inCred--;
                sent++;
                modelInstr(w);
                @(negedge clk);
                inValid = 1'b0;
        endtask

        task automatic checkRecord();
                corePkg::retireRec_t e;
                compareVal("record expected", expQ.size() > 0, 1);
                if (expQ.size() > 0) begin
                        e = expQ.pop_front();
                        compareVal($sformatf("record %0d wrEn", received), retRec.wrEn, e.wrEn);
                        compareVal($sformatf("record %0d halt", received), retRec.halt, e.halt);
                        compareVal($sformatf("record %0d illegal", received),
                                   retRec.illegal, e.illegal);
                        if (e.wrEn) begin
                                compareVal($sformatf("record %0d wrIdx", received),
                                           retRec.wrIdx, e.wrIdx);
                                compareVal($sformatf("record %0d result", received),
                                           retRec.result, e.result);
                        end
                end
        endtask

        task automatic endTest(input string name, input int errBefore, input int sentBefore);
                while (received < sent)
                        @(negedge clk);
                repeat (2) @(negedge clk);
                compareVal({name, " inCredit pulses"}, creditsBack, sent);
                tests++;
                $display("Test %s: %0d sent, %0d retired, %0d errors", name,
                         sent - sentBefore, received - sentBefore, errors - errBefore);
        endtask

        task automatic runRandom(input string name, input int count, input int idlePct,
                                 input int crPct);
                int errBefore, sentBefore;
                errBefore  = errors;
                sentBefore = sent;
                credPct    = crPct;
                repeat (count) begin
                        while ($urandom_range(0, 99) < idlePct)
                                @(negedge clk);
                        sendInstr(randInstr());
                end
                endTest(name, errBefore, sentBefore);
        endtask

        // Mirror of both credit counts, checked as records leave
        always @(posedge clk) begin
                if (arstN) begin
                        if (retValid) begin
                                compareVal("output credit held at retValid", coreCred > 0, 1);
                                coreCred--;
                                owed++;
                                received++;
                                checkRecord();
                        end
                        if (outCredit)
                                coreCred++;
                        if (inCredit) begin
                                inCred++;
                                creditsBack++;
                        end
                end
        end

        always @(negedge clk) begin
                outCredit = 1'b0;
                if (owed > 0 && $urandom_range(0, 99) < credPct) begin
                        outCredit = 1'b1;
                        owed--;
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles > CycleLimit) begin
                        $display("Timeout after %0d cycles: %0d of %0d retire records never arrived",
                                 cycles, sent - received, sent);
                        $display("Done: errors found");
                        $finish;
                end
        end

        initial begin
                int errBefore;
                void'($urandom(50));
                clk       = 1'b0;
                arstN     = 1'b0;
                inValid   = 1'b0;
                inInstr   = '0;
                outCredit = 1'b0;
                inCred    = `CORE_IN_DEPTH;
                coreCred  = `CORE_OUT_CREDITS;
                credPct   = 100;
                for (int i = 0; i < `CORE_NUM_REGS; i++)
                        modelRegs[i] = '0;

                errBefore = errors;
                repeat (2) @(negedge clk);
                compareVal("retValid in reset", retValid, 0);
                compareVal("inCredit in reset", inCredit, 0);
                arstN = 1'b1;
                @(negedge clk);
                compareVal("retValid after reset", retValid, 0);
                compareVal("inCredit after reset", inCredit, 0);
                tests++;
                $display("Test reset: %0d errors", errors - errBefore);

                dirSeq = '{
                        {5'b11011, 3'd5, 3'd6, 3'd4, 2'd0},     // ADD of unwritten regs
                        {5'b01001, 3'd2, 3'd1, 5'h1F},          // SUBI r1 = -1 - r2
                        {5'b11000, 3'd1, 8'h85},                // LBI negative byte
                        {5'b10010, 3'd1, 8'h3C},                // SLBI through bypass
                        {5'b11101, 3'd1, 3'd0, 3'd2, 2'd0},     // SLT r2
                        {5'b11111, 3'd1, 3'd1, 3'd3, 2'd0},     // SCO r3
                        {5'b11010, 3'd1, 3'd3, 3'd5, 2'd0},     // ROL r5 by r3
                        {5'b00000, 11'd0},
                        {5'b10000, 11'h7FF}                     // Store is illegal here
                };
                errBefore = errors;
                foreach (dirSeq[i])
                        sendInstr(dirSeq[i]);
                endTest("directed", errBefore, 0);

                runRandom("randomFast", FastLen, 20, 90);
                runRandom("backPressure", SlowLen, 5, 15);

                $display("Summary: %0d tests, %0d instructions, %0d records, %0d errors",
                         tests, sent, received, errors);
                if (errors == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/corePkg.sv
logic/instrQueue.sv
logic/controlDecode.sv
logic/regFile.sv
logic/executeStage.sv
logic/retireStage.sv
logic/coreTop.sv
bench/tbCore.sv

// File: Bender.yml
package:
  name: wisc_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/corePkg.sv
      - logic/instrQueue.sv
      - logic/controlDecode.sv
      - logic/regFile.sv
      - logic/executeStage.sv
      - logic/retireStage.sv
      - logic/coreTop.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/tbCore.sv
